// File: include/pr_config.svh
`ifndef PR_CONFIG_SVH
`define PR_CONFIG_SVH

// score and memory word width
`define PR_WORD_W 64
// fixed-point fraction bits of a score
`define PR_FRAC_W 16
// log2 of the decoupling FIFO depth
`define PR_FIFO_LOG 4

// soft-register byte addresses, one 64-bit word apart
`define PR_REG_NVERT       32'h00
`define PR_REG_NEDGE       32'h08
`define PR_REG_VBASE       32'h10
`define PR_REG_EBASE       32'h18
`define PR_REG_ADDR0       32'h20
`define PR_REG_ADDR1       32'h28
`define PR_REG_ROUNDS      32'h30
// write only, kicks off a run
`define PR_REG_START       32'h38
// read only status words
`define PR_REG_STATE       32'h40
`define PR_REG_DONE_ROUNDS 32'h48

`endif

// File: source/pr_pkg.sv
`default_nettype none

`include "pr_config.svh"

package pr_pkg;

	// one memory word: a score, an address or an edge index
	typedef logic [`PR_WORD_W-1:0] pr_word_t;

	// vertex array entry, in-degree in the upper half
	typedef struct packed {
		logic [31:0] in_deg;
		logic [31:0] out_deg;
	} vert_entry_t;

	// round controller states, readable through PR_REG_STATE
	typedef enum logic [2:0] {
		IDLE,
		INIT,
		RUN,
		SWAP,
		DONE
	} pr_state_e;

	// kind of the single outstanding memory read
	typedef enum logic [1:0] {
		TAG_VERT,
		TAG_EDGE,
		TAG_SCORE
	} rd_tag_e;

	// vertex engine states
	typedef enum logic [1:0] {
		E_INIT,
		E_VERT,
		E_SUM,
		E_ISSUE
	} eng_state_e;

endpackage

`default_nettype wire

// File: source/pr_round_if.sv
`timescale 1ns/100ps
`default_nettype none

interface pr_round_if import pr_pkg::*; ();

	// one-cycle pulse at the start of every round
	logic start;
	// high for the whole of round 1
	logic first_round;
	logic [31:0] n_vertices;
	logic [31:0] n_edges;
	pr_word_t vert_base;
	pr_word_t edge_base;
	// old scores are read here, new scores written there
	pr_word_t rd_base;
	pr_word_t wr_base;
	// pulse once the last score write of a round is answered
	logic round_done;

	modport ctrl (
		output start, first_round, n_vertices, n_edges,
		output vert_base, edge_base, rd_base, wr_base,
		input round_done
	);

	modport fetch (
		input start, first_round, n_vertices, n_edges,
		input vert_base, edge_base, rd_base
	);

	modport engine (
		input start, first_round, n_vertices
	);

	modport wb (
		input start, n_vertices, wr_base,
		output round_done
	);

endinterface

`default_nettype wire

// File: source/pr_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module pr_fifo #(
	parameter int WIDTH = 64,
	parameter int LOG_DEPTH = 4
) (
	input wire clk,
	input wire rst,
	input wire push,
	input wire [WIDTH-1:0] din,
	output logic full,
	input wire pop,
	output logic [WIDTH-1:0] dout,
	output logic empty
);

	logic [WIDTH-1:0] mem [2**LOG_DEPTH];
	logic [LOG_DEPTH-1:0] wr_ptr;
	logic [LOG_DEPTH-1:0] rd_ptr;
	// one extra bit so that a full FIFO is told apart from an empty one
	logic [LOG_DEPTH:0] count;
	logic do_push;
	logic do_pop;

	// count never exceeds the depth, so the top bit alone means full
	assign full = count[LOG_DEPTH];
	assign empty = (count == '0);
	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	// first word falls through, the head is always on dout
	assign dout = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + (LOG_DEPTH+1)'(do_push) - (LOG_DEPTH+1)'(do_pop);
		end
	end

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= din;
	end

endmodule

`default_nettype wire

// File: source/pr_divider.sv
`timescale 1ns/100ps
`default_nettype none

module pr_divider import pr_pkg::*; (
	input wire clk,
	input wire rst,
	input wire start,
	input wire pr_word_t dividend,
	input wire [31:0] divisor,
	output logic busy,
	output logic done,
	output pr_word_t quotient
);

	// partial remainder, always below the divisor
	logic [31:0] rem;
	logic [31:0] div_r;
	logic [5:0] steps_left;

	logic [31:0] src_rem;
	logic [31:0] src_div;
	pr_word_t src_q;
	logic [32:0] shifted;
	logic ge;
	logic [31:0] rem_next;

	// one restoring step; the start cycle already does the first one
	// quotient doubles as the dividend shift register
	always_comb begin
		src_rem = start ? 32'd0 : rem;
		src_q = start ? dividend : quotient;
		src_div = start ? divisor : div_r;
		shifted = {src_rem, src_q[63]};
		ge = (shifted >= {1'b0, src_div});
		rem_next = ge ? 32'(shifted - {1'b0, src_div}) : shifted[31:0];
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			done <= 1'b0;
			steps_left <= '0;
		end else begin
			done <= 1'b0;
			if (start) begin
				busy <= 1'b1;
				steps_left <= 6'd63;
			end else if (busy) begin
				steps_left <= steps_left - 1'b1;
				// 64th bit lands now, done follows 64 cycles after start
				if (steps_left == 6'd1) begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start || busy) begin
			rem <= rem_next;
			quotient <= {src_q[62:0], ge};
		end
		if (start)
			div_r <= divisor;
	end

	// the engine waits for done before the next division
	a_no_start_busy: assert property (
		@(posedge clk) disable iff (rst) !(start && busy)
	);

endmodule

`default_nettype wire

// File: source/pr_control.sv
`timescale 1ns/100ps
`default_nettype none

`include "pr_config.svh"

module pr_control import pr_pkg::*; (
	input wire clk,
	input wire rst,
	input wire softreg_req_valid,
	input wire softreg_req_is_write,
	input wire [31:0] softreg_req_addr,
	input wire pr_word_t softreg_req_data,
	output logic softreg_resp_valid,
	output pr_word_t softreg_resp_data,
	pr_round_if.ctrl rnd
);

	pr_state_e state;
	logic [31:0] total_rounds;
	logic [31:0] done_rounds;
	logic reg_wr;
	logic start_wr;

	assign reg_wr = softreg_req_valid && softreg_req_is_write;
	assign start_wr = reg_wr && (softreg_req_addr == `PR_REG_START);

	// the initial-value round is the one entered through INIT
	assign rnd.first_round = (state == INIT);

	// graph parameters and score bases, swapped between rounds
	always_ff @(posedge clk) begin
		if (reg_wr) begin
			case (softreg_req_addr)
				`PR_REG_NVERT: rnd.n_vertices <= softreg_req_data[31:0];
				`PR_REG_NEDGE: rnd.n_edges <= softreg_req_data[31:0];
				`PR_REG_VBASE: rnd.vert_base <= softreg_req_data;
				`PR_REG_EBASE: rnd.edge_base <= softreg_req_data;
				`PR_REG_ADDR0: rnd.rd_base <= softreg_req_data;
				`PR_REG_ADDR1: rnd.wr_base <= softreg_req_data;
				`PR_REG_ROUNDS: total_rounds <= softreg_req_data[31:0];
				default: ;
			endcase
		end
		// this round's output becomes next round's input
		if (state == SWAP) begin
			rnd.rd_base <= rnd.wr_base;
			rnd.wr_base <= rnd.rd_base;
		end
	end

	// round sequencing
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			rnd.start <= 1'b0;
			done_rounds <= '0;
		end else begin
			rnd.start <= 1'b0;
			case (state)
				IDLE, DONE: begin
					// a finished run may be started again with new parameters
					if (start_wr) begin
						state <= INIT;
						rnd.start <= 1'b1;
						done_rounds <= '0;
					end
				end
				INIT, RUN: begin
					if (rnd.round_done)
						state <= SWAP;
				end
				SWAP: begin
					done_rounds <= done_rounds + 1'b1;
					if (done_rounds + 1'b1 >= total_rounds) begin
						state <= DONE;
					end else begin
						state <= RUN;
						rnd.start <= 1'b1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// reads answer exactly one cycle after the request
	always_ff @(posedge clk) begin
		if (rst)
			softreg_resp_valid <= 1'b0;
		else
			softreg_resp_valid <= softreg_req_valid && !softreg_req_is_write;
	end

	always_ff @(posedge clk) begin
		if (softreg_req_valid && !softreg_req_is_write) begin
			case (softreg_req_addr)
				`PR_REG_NVERT: softreg_resp_data <= pr_word_t'(rnd.n_vertices);
				`PR_REG_NEDGE: softreg_resp_data <= pr_word_t'(rnd.n_edges);
				`PR_REG_VBASE: softreg_resp_data <= rnd.vert_base;
				`PR_REG_EBASE: softreg_resp_data <= rnd.edge_base;
				// current read and write bases, swapped after each round
				`PR_REG_ADDR0: softreg_resp_data <= rnd.rd_base;
				`PR_REG_ADDR1: softreg_resp_data <= rnd.wr_base;
				`PR_REG_ROUNDS: softreg_resp_data <= pr_word_t'(total_rounds);
				`PR_REG_STATE: softreg_resp_data <= pr_word_t'(state);
				`PR_REG_DONE_ROUNDS: softreg_resp_data <= pr_word_t'(done_rounds);
				default: softreg_resp_data <= '0;
			endcase
		end
	end

	// writeback only finishes rounds that this controller started
	a_no_done_in_idle: assert property (
		@(posedge clk) disable iff (rst) rnd.round_done |-> (state != IDLE)
	);

endmodule

`default_nettype wire

// File: source/pr_mem_reader.sv
`timescale 1ns/100ps
`default_nettype none

`include "pr_config.svh"

module pr_mem_reader import pr_pkg::*; (
	input wire clk,
	input wire rst,
	output pr_word_t m_araddr,
	output logic [2:0] m_arprot,
	output logic m_arvalid,
	input wire m_arready,
	input wire pr_word_t m_rdata,
	input wire [1:0] m_rresp,
	input wire m_rvalid,
	output logic m_rready,
	pr_round_if.fetch rnd,
	output logic vert_valid,
	input wire vert_ready,
	output vert_entry_t vert_data,
	output logic score_valid,
	input wire score_ready,
	output pr_word_t score_data
);

	// words still to fetch this round
	logic [31:0] vert_left;
	logic [31:0] edge_left;
	pr_word_t vert_addr;
	pr_word_t edge_addr;
	// set from issue until the response, one read in flight at most
	logic rd_busy;
	rd_tag_e tag;

	logic can_issue;
	logic issue_score;
	logic issue_edge;
	logic issue_vert;

	logic vert_full;
	logic vert_empty;
	pr_word_t vert_q;
	logic edge_full;
	logic edge_empty;
	pr_word_t edge_head;
	logic score_full;
	logic score_empty;

	assign m_arprot = 3'b000;
	assign m_rready = 1'b1;

	// priority: score lookups, then edges, then vertices
	// a FIFO with room at issue still has room at the response,
	// since nothing else is pushed while the read is in flight
	assign can_issue = !rd_busy && !rnd.start;
	assign issue_score = can_issue && !edge_empty && !score_full;
	assign issue_edge = can_issue && !issue_score && (edge_left != '0) && !edge_full;
	assign issue_vert = can_issue && !issue_score && !issue_edge
		&& (vert_left != '0) && !vert_full;

	always_ff @(posedge clk) begin
		if (rst) begin
			m_arvalid <= 1'b0;
			rd_busy <= 1'b0;
			vert_left <= '0;
			edge_left <= '0;
		end else begin
			if (rnd.start) begin
				vert_left <= rnd.n_vertices;
				// round 1 uses the initial value, no edges needed
				edge_left <= rnd.first_round ? '0 : rnd.n_edges;
			end
			if (m_arvalid && m_arready)
				m_arvalid <= 1'b0;
			if (m_rvalid)
				rd_busy <= 1'b0;
			if (issue_score || issue_edge || issue_vert) begin
				m_arvalid <= 1'b1;
				rd_busy <= 1'b1;
			end
			if (issue_edge)
				edge_left <= edge_left - 1'b1;
			if (issue_vert)
				vert_left <= vert_left - 1'b1;
		end
	end

	// address and tag of the next read
	always_ff @(posedge clk) begin
		if (rnd.start) begin
			vert_addr <= rnd.vert_base;
			edge_addr <= rnd.edge_base;
		end
		if (issue_score) begin
			// old score of the source vertex at the edge FIFO head
			m_araddr <= rnd.rd_base + {edge_head[60:0], 3'b000};
			tag <= TAG_SCORE;
		end else if (issue_edge) begin
			m_araddr <= edge_addr;
			edge_addr <= edge_addr + 8;
			tag <= TAG_EDGE;
		end else if (issue_vert) begin
			m_araddr <= vert_addr;
			vert_addr <= vert_addr + 8;
			tag <= TAG_VERT;
		end
	end

	pr_fifo #(
		.WIDTH(`PR_WORD_W),
		.LOG_DEPTH(`PR_FIFO_LOG)
	) u_vert_fifo (
		.clk(clk),
		.rst(rst),
		.push(m_rvalid && (tag == TAG_VERT)),
		.din(m_rdata),
		.full(vert_full),
		.pop(vert_valid && vert_ready),
		.dout(vert_q),
		.empty(vert_empty)
	);

	// edge indices wait here until their score read is issued
	pr_fifo #(
		.WIDTH(`PR_WORD_W),
		.LOG_DEPTH(`PR_FIFO_LOG)
	) u_edge_fifo (
		.clk(clk),
		.rst(rst),
		.push(m_rvalid && (tag == TAG_EDGE)),
		.din(m_rdata),
		.full(edge_full),
		.pop(issue_score),
		.dout(edge_head),
		.empty(edge_empty)
	);

	pr_fifo #(
		.WIDTH(`PR_WORD_W),
		.LOG_DEPTH(`PR_FIFO_LOG)
	) u_score_fifo (
		.clk(clk),
		.rst(rst),
		.push(m_rvalid && (tag == TAG_SCORE)),
		.din(m_rdata),
		.full(score_full),
		.pop(score_valid && score_ready),
		.dout(score_data),
		.empty(score_empty)
	);

	assign vert_valid = !vert_empty;
	assign vert_data = vert_entry_t'(vert_q);
	assign score_valid = !score_empty;

	// a response only comes back for an accepted address, and always OKAY
	a_rvalid_outstanding: assert property (
		@(posedge clk) disable iff (rst)
		m_rvalid |-> (rd_busy && !m_arvalid && (m_rresp == 2'b00))
	);

endmodule

`default_nettype wire

// File: source/pr_vertex_engine.sv
`timescale 1ns/100ps
`default_nettype none

`include "pr_config.svh"

module pr_vertex_engine import pr_pkg::*; (
	input wire clk,
	input wire rst,
	pr_round_if.engine rnd,
	input wire vert_valid,
	output logic vert_ready,
	input wire vert_entry_t vert_data,
	input wire score_valid,
	output logic score_ready,
	input wire pr_word_t score_data,
	output logic res_valid,
	input wire res_ready,
	output pr_word_t res_data
);

	eng_state_e state;
	// vertices left this round
	logic [31:0] vert_left;
	// in-edges of the current vertex still to add
	logic [31:0] deg_left;
	logic [31:0] out_deg;
	pr_word_t sum;
	// 1/N in fixed point, computed once at the start of round 1
	pr_word_t init_val;

	logic div_start;
	pr_word_t div_dividend;
	logic [31:0] div_divisor;
	logic div_busy;
	logic div_done;
	pr_word_t div_quot;

	// E_VERT with no vertices left is the idle state between rounds
	assign vert_ready = (state == E_VERT) && (vert_left != '0);
	// round 1 adds init_val instead of old scores
	assign score_ready = (state == E_SUM) && (deg_left != '0) && !rnd.first_round;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= E_VERT;
			vert_left <= '0;
			div_start <= 1'b0;
			res_valid <= 1'b0;
		end else begin
			div_start <= 1'b0;
			if (rnd.start) begin
				vert_left <= rnd.n_vertices;
				if (rnd.first_round) begin
					// init_val = 2^frac / N
					state <= E_INIT;
					div_start <= 1'b1;
					div_dividend <= pr_word_t'(1) << `PR_FRAC_W;
					div_divisor <= rnd.n_vertices;
				end else begin
					state <= E_VERT;
				end
			end else begin
				case (state)
					E_INIT: begin
						if (div_done) begin
							init_val <= div_quot;
							state <= E_VERT;
						end
					end
					E_VERT: begin
						if (vert_ready && vert_valid) begin
							vert_left <= vert_left - 1'b1;
							deg_left <= vert_data.in_deg;
							out_deg <= vert_data.out_deg;
							sum <= '0;
							state <= E_SUM;
						end
					end
					E_SUM: begin
						if (deg_left == '0) begin
							if (!div_busy) begin
								state <= E_ISSUE;
								if (out_deg == '0) begin
									// no out-edges, pass the sum through
									res_data <= sum;
									res_valid <= 1'b1;
								end else begin
									div_start <= 1'b1;
									div_dividend <= sum;
									div_divisor <= out_deg;
								end
							end
						end else if (rnd.first_round) begin
							sum <= sum + init_val;
							deg_left <= deg_left - 1'b1;
						end else if (score_valid) begin
							sum <= sum + score_data;
							deg_left <= deg_left - 1'b1;
						end
					end
					E_ISSUE: begin
						if (div_done) begin
							res_data <= div_quot;
							res_valid <= 1'b1;
						end
						// hold the result until writeback takes it
						if (res_valid && res_ready) begin
							res_valid <= 1'b0;
							state <= E_VERT;
						end
					end
					default: state <= E_VERT;
				endcase
			end
		end
	end

	pr_divider u_divider (
		.clk(clk),
		.rst(rst),
		.start(div_start),
		.dividend(div_dividend),
		.divisor(div_divisor),
		.busy(div_busy),
		.done(div_done),
		.quotient(div_quot)
	);

	// the reader fetches no old scores during round 1
	a_no_score_first_round: assert property (
		@(posedge clk) disable iff (rst) rnd.first_round |-> !score_valid
	);

endmodule

`default_nettype wire

// File: source/pr_writeback.sv
`timescale 1ns/100ps
`default_nettype none

module pr_writeback import pr_pkg::*; (
	input wire clk,
	input wire rst,
	output pr_word_t m_awaddr,
	output logic [2:0] m_awprot,
	output logic m_awvalid,
	input wire m_awready,
	output pr_word_t m_wdata,
	output logic [7:0] m_wstrb,
	output logic m_wvalid,
	input wire m_wready,
	input wire [1:0] m_bresp,
	input wire m_bvalid,
	output logic m_bready,
	pr_round_if.wb rnd,
	input wire res_valid,
	output logic res_ready,
	input wire pr_word_t res_data
);

	// a write is in flight until its response
	logic busy;
	// vertex index of the result being written
	logic [31:0] idx;

	assign m_awprot = 3'b000;
	// whole aligned word every time
	assign m_wstrb = 8'hff;
	assign m_bready = 1'b1;
	assign res_ready = !busy;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			m_awvalid <= 1'b0;
			m_wvalid <= 1'b0;
			idx <= '0;
			rnd.round_done <= 1'b0;
		end else begin
			rnd.round_done <= 1'b0;
			if (rnd.start)
				idx <= '0;
			// address and data channels complete independently
			if (m_awvalid && m_awready)
				m_awvalid <= 1'b0;
			if (m_wvalid && m_wready)
				m_wvalid <= 1'b0;
			if (res_valid && res_ready) begin
				busy <= 1'b1;
				m_awvalid <= 1'b1;
				m_wvalid <= 1'b1;
				m_awaddr <= rnd.wr_base + pr_word_t'({idx, 3'b000});
				m_wdata <= res_data;
			end
			if (m_bvalid) begin
				busy <= 1'b0;
				if (idx == rnd.n_vertices - 1'b1) begin
					idx <= '0;
					rnd.round_done <= 1'b1;
				end else begin
					idx <= idx + 1'b1;
				end
			end
		end
	end

	// a pending address stays valid and keeps its value until taken
	a_awvalid_hold: assert property (
		@(posedge clk) disable iff (rst)
		(m_awvalid && !m_awready) |=> (m_awvalid && $stable(m_awaddr))
	);

	// responses only for our own write, and always OKAY
	a_bvalid_expected: assert property (
		@(posedge clk) disable iff (rst) m_bvalid |-> (busy && (m_bresp == 2'b00))
	);

endmodule

`default_nettype wire

// File: source/pagerank_top.sv
`timescale 1ns/100ps
`default_nettype none

module pagerank_top import pr_pkg::*; (
	input wire clk,
	input wire rst,

	// AXI4-Lite read channels
	output pr_word_t m_araddr,
	output logic [2:0] m_arprot,
	output logic m_arvalid,
	input wire m_arready,
	input wire pr_word_t m_rdata,
	input wire [1:0] m_rresp,
	input wire m_rvalid,
	output logic m_rready,

	// AXI4-Lite write channels
	output pr_word_t m_awaddr,
	output logic [2:0] m_awprot,
	output logic m_awvalid,
	input wire m_awready,
	output pr_word_t m_wdata,
	output logic [7:0] m_wstrb,
	output logic m_wvalid,
	input wire m_wready,
	input wire [1:0] m_bresp,
	input wire m_bvalid,
	output logic m_bready,

	// host soft-register port
	input wire softreg_req_valid,
	input wire softreg_req_is_write,
	input wire [31:0] softreg_req_addr,
	input wire pr_word_t softreg_req_data,
	output logic softreg_resp_valid,
	output pr_word_t softreg_resp_data
);

	logic vert_valid;
	logic vert_ready;
	vert_entry_t vert_data;
	logic score_valid;
	logic score_ready;
	pr_word_t score_data;
	logic res_valid;
	logic res_ready;
	pr_word_t res_data;

	// per-round settings and completion
	pr_round_if rnd ();

	pr_control u_control (
		.clk(clk),
		.rst(rst),
		.softreg_req_valid(softreg_req_valid),
		.softreg_req_is_write(softreg_req_is_write),
		.softreg_req_addr(softreg_req_addr),
		.softreg_req_data(softreg_req_data),
		.softreg_resp_valid(softreg_resp_valid),
		.softreg_resp_data(softreg_resp_data),
		.rnd(rnd.ctrl)
	);

	pr_mem_reader u_mem_reader (
		.clk(clk),
		.rst(rst),
		.m_araddr(m_araddr),
		.m_arprot(m_arprot),
		.m_arvalid(m_arvalid),
		.m_arready(m_arready),
		.m_rdata(m_rdata),
		.m_rresp(m_rresp),
		.m_rvalid(m_rvalid),
		.m_rready(m_rready),
		.rnd(rnd.fetch),
		.vert_valid(vert_valid),
		.vert_ready(vert_ready),
		.vert_data(vert_data),
		.score_valid(score_valid),
		.score_ready(score_ready),
		.score_data(score_data)
	);

	pr_vertex_engine u_vertex_engine (
		.clk(clk),
		.rst(rst),
		.rnd(rnd.engine),
		.vert_valid(vert_valid),
		.vert_ready(vert_ready),
		.vert_data(vert_data),
		.score_valid(score_valid),
		.score_ready(score_ready),
		.score_data(score_data),
		.res_valid(res_valid),
		.res_ready(res_ready),
		.res_data(res_data)
	);

	pr_writeback u_writeback (
		.clk(clk),
		.rst(rst),
		.m_awaddr(m_awaddr),
		.m_awprot(m_awprot),
		.m_awvalid(m_awvalid),
		.m_awready(m_awready),
		.m_wdata(m_wdata),
		.m_wstrb(m_wstrb),
		.m_wvalid(m_wvalid),
		.m_wready(m_wready),
		.m_bresp(m_bresp),
		.m_bvalid(m_bvalid),
		.m_bready(m_bready),
		.rnd(rnd.wb),
		.res_valid(res_valid),
		.res_ready(res_ready),
		.res_data(res_data)
	);

endmodule

`default_nettype wire

// File: bench/pr_mem_model.sv
`timescale 1ns/100ps
`default_nettype none

module pr_mem_model import pr_pkg::*; #(
	parameter int LOG_WORDS = 11
) (
	input wire clk,
	input wire rst,
	// one stall bit per channel: ar, r, aw, w, b
	input wire [4:0] stall,
	input wire pr_word_t araddr,
	input wire arvalid,
	output logic arready,
	output pr_word_t rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input wire rready,
	input wire pr_word_t awaddr,
	input wire awvalid,
	output logic awready,
	input wire pr_word_t wdata,
	input wire [7:0] wstrb,
	input wire wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input wire bready
);

	// word array, also loaded and inspected directly by the testbench
	pr_word_t mem [2**LOG_WORDS];

	// read accepted, data not yet returned
	logic rd_pend;
	pr_word_t rd_addr;
	// write address and data are captured independently
	logic aw_got;
	logic w_got;
	pr_word_t wr_addr;
	pr_word_t wr_data;
	logic [7:0] wr_strb;
	logic wr_commit;

	assign arready = !rd_pend && !stall[0];
	assign awready = !aw_got && !stall[2];
	assign wready = !w_got && !stall[3];
	// every response is OKAY
	assign rresp = 2'b00;
	assign bresp = 2'b00;
	assign wr_commit = aw_got && w_got && !bvalid && !stall[4];

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_pend <= 1'b0;
			rvalid <= 1'b0;
			aw_got <= 1'b0;
			w_got <= 1'b0;
			bvalid <= 1'b0;
		end else begin
			if (arvalid && arready) begin
				rd_pend <= 1'b1;
				rd_addr <= araddr;
			end
			if (rvalid && rready) begin
				rvalid <= 1'b0;
				rd_pend <= 1'b0;
			end else if (rd_pend && !rvalid && !stall[1]) begin
				rvalid <= 1'b1;
				rdata <= mem[rd_addr[LOG_WORDS+2:3]];
			end
			if (awvalid && awready) begin
				aw_got <= 1'b1;
				wr_addr <= awaddr;
			end
			if (wvalid && wready) begin
				w_got <= 1'b1;
				wr_data <= wdata;
				wr_strb <= wstrb;
			end
			// response goes out in the cycle the word is stored
			if (bvalid && bready) begin
				bvalid <= 1'b0;
				aw_got <= 1'b0;
				w_got <= 1'b0;
			end else if (wr_commit) begin
				bvalid <= 1'b1;
			end
		end
	end

	// byte lanes follow wstrb
	always @(posedge clk) begin
		if (!rst && wr_commit) begin
			for (int b = 0; b < 8; b++) begin
				if (wr_strb[b])
					mem[wr_addr[LOG_WORDS+2:3]][8*b +: 8] <= wr_data[8*b +: 8];
			end
		end
	end

endmodule

`default_nettype wire

// File: bench/tb_pagerank.sv
`timescale 1ns/100ps
`default_nettype none

`include "pr_config.svh"

module tb_pagerank import pr_pkg::*;;

	localparam int N_VERT = 16;
	localparam int MAX_E = 48;
	localparam int POLL_LIMIT = 50000;
	// 1/N in the score format
	localparam logic [63:0] INIT_SCORE = 64'(65536 / N_VERT);
	// byte bases of the graph and the two score arrays
	localparam logic [63:0] VBASE = 64'h0000;
	localparam logic [63:0] EBASE = 64'h1000;
	localparam logic [63:0] ADDR0 = 64'h2000;
	localparam logic [63:0] ADDR1 = 64'h3000;

	logic clk;
	logic rst;
	logic softreg_req_valid;
	logic softreg_req_is_write;
	logic [31:0] softreg_req_addr;
	logic [63:0] softreg_req_data;
	logic softreg_resp_valid;
	logic [63:0] softreg_resp_data;

	logic [63:0] m_araddr;
	logic [2:0] m_arprot;
	logic m_arvalid;
	logic m_arready;
	logic [63:0] m_rdata;
	logic [1:0] m_rresp;
	logic m_rvalid;
	logic m_rready;
	logic [63:0] m_awaddr;
	logic [2:0] m_awprot;
	logic m_awvalid;
	logic m_awready;
	logic [63:0] m_wdata;
	logic [7:0] m_wstrb;
	logic m_wvalid;
	logic m_wready;
	logic [1:0] m_bresp;
	logic m_bvalid;
	logic m_bready;

	logic [4:0] stall;
	logic stall_en;
	logic [31:0] lfsr;

	// graph: in-edges grouped by destination in vertex order
	int in_deg [N_VERT];
	int out_deg [N_VERT];
	int edge_src [MAX_E];
	int n_edges;
	logic [63:0] exp_score [N_VERT];
	logic [63:0] rd_val;

	pagerank_top u_pagerank_top (
		.clk(clk),
		.rst(rst),
		.m_araddr(m_araddr),
		.m_arprot(m_arprot),
		.m_arvalid(m_arvalid),
		.m_arready(m_arready),
		.m_rdata(m_rdata),
		.m_rresp(m_rresp),
		.m_rvalid(m_rvalid),
		.m_rready(m_rready),
		.m_awaddr(m_awaddr),
		.m_awprot(m_awprot),
		.m_awvalid(m_awvalid),
		.m_awready(m_awready),
		.m_wdata(m_wdata),
		.m_wstrb(m_wstrb),
		.m_wvalid(m_wvalid),
		.m_wready(m_wready),
		.m_bresp(m_bresp),
		.m_bvalid(m_bvalid),
		.m_bready(m_bready),
		.softreg_req_valid(softreg_req_valid),
		.softreg_req_is_write(softreg_req_is_write),
		.softreg_req_addr(softreg_req_addr),
		.softreg_req_data(softreg_req_data),
		.softreg_resp_valid(softreg_resp_valid),
		.softreg_resp_data(softreg_resp_data)
	);

	pr_mem_model u_mem_model (
		.clk(clk),
		.rst(rst),
		.stall(stall),
		.araddr(m_araddr),
		.arvalid(m_arvalid),
		.arready(m_arready),
		.rdata(m_rdata),
		.rresp(m_rresp),
		.rvalid(m_rvalid),
		.rready(m_rready),
		.awaddr(m_awaddr),
		.awvalid(m_awvalid),
		.awready(m_awready),
		.wdata(m_wdata),
		.wstrb(m_wstrb),
		.wvalid(m_wvalid),
		.wready(m_wready),
		.bresp(m_bresp),
		.bvalid(m_bvalid),
		.bready(m_bready)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one step per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	// random ready stalls on all five channels
	always @(posedge clk) begin
		#1;
		if (stall_en)
			stall = 5'(take_bits(5));
		else
			stall = '0;
	end

	// background word, different at every byte address
	function automatic logic [63:0] fill_word(input int word);
		logic [31:0] addr;
		addr = 32'(word) << 3;
		return {addr ^ 32'h5a5a_5a5a, ~addr};
	endfunction

	task automatic compare(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		if (expected !== actual) begin
			$display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
			$display("TEST FAILED");
			$fatal(1, "value mismatch in %s", name);
		end
	endtask

	// fixed AXI4-Lite side signals, sampled mid-cycle
	always @(negedge clk) begin
		if (!rst) begin
			compare("read data ready", 64'd1, 64'(m_rready));
			compare("write response ready", 64'd1, 64'(m_bready));
			if (m_arvalid)
				compare("read address protection", 64'd0, 64'(m_arprot));
			if (m_awvalid)
				compare("write address protection", 64'd0, 64'(m_awprot));
			if (m_wvalid)
				compare("write strobe", 64'hff, 64'(m_wstrb));
		end
	end

	// vertex 0 has no in-edges, vertex N-1 is never a source
	task automatic build_graph();
		int src;
		n_edges = 0;
		for (int v = 0; v < N_VERT; v++)
			out_deg[v] = 0;
		for (int v = 0; v < N_VERT; v++) begin
			in_deg[v] = int'(take_bits(2));
			if (v == 0)
				in_deg[v] = 0;
			if (v == N_VERT - 1)
				in_deg[v] = in_deg[v] | 1;
			for (int k = 0; k < in_deg[v]; k++) begin
				src = int'(take_bits(4)) % (N_VERT - 1);
				edge_src[n_edges] = src;
				out_deg[src] = out_deg[src] + 1;
				n_edges = n_edges + 1;
			end
		end
	endtask

	task automatic load_memory();
		for (int i = 0; i < 2048; i++)
			u_mem_model.mem[i] = fill_word(i);
		for (int v = 0; v < N_VERT; v++)
			u_mem_model.mem[int'(VBASE >> 3) + v] = {32'(in_deg[v]), 32'(out_deg[v])};
		for (int e = 0; e < n_edges; e++)
			u_mem_model.mem[int'(EBASE >> 3) + e] = 64'(edge_src[e]);
	endtask

	// expected scores after the given number of rounds
	function automatic void pr_expect(input int rounds);
		logic [63:0] prev [N_VERT];
		logic [63:0] acc;
		int e;
		for (int v = 0; v < N_VERT; v++)
			prev[v] = '0;
		for (int r = 1; r <= rounds; r++) begin
			e = 0;
			for (int v = 0; v < N_VERT; v++) begin
				acc = '0;
				for (int k = 0; k < in_deg[v]; k++) begin
					if (r == 1)
						acc = acc + INIT_SCORE;
					else
						acc = acc + prev[edge_src[e]];
					e = e + 1;
				end
				// a sink keeps its whole sum
				if (out_deg[v] == 0)
					exp_score[v] = acc;
				else
					exp_score[v] = acc / 64'(out_deg[v]);
			end
			prev = exp_score;
		end
	endfunction

	task automatic reg_write(input logic [31:0] addr, input logic [63:0] data);
		@(posedge clk);
		#1;
		softreg_req_valid = 1'b1;
		softreg_req_is_write = 1'b1;
		softreg_req_addr = addr;
		softreg_req_data = data;
		@(posedge clk);
		#1;
		softreg_req_valid = 1'b0;
		softreg_req_is_write = 1'b0;
	endtask

	// response must be there one cycle after the request
	task automatic reg_read(input logic [31:0] addr, output logic [63:0] data);
		@(posedge clk);
		#1;
		softreg_req_valid = 1'b1;
		softreg_req_is_write = 1'b0;
		softreg_req_addr = addr;
		@(posedge clk);
		#1;
		softreg_req_valid = 1'b0;
		compare("softreg response timing", 64'd1, 64'(softreg_resp_valid));
		data = softreg_resp_data;
	endtask

	task automatic wait_done(input int rounds);
		logic [63:0] st;
		int polls;
		st = '0;
		polls = 0;
		while (st != 64'(DONE)) begin
			if (polls == POLL_LIMIT) begin
				$display("TEST FAILED");
				$fatal(1, "run of %0d rounds never reached the DONE state", rounds);
			end
			reg_read(`PR_REG_STATE, st);
			polls = polls + 1;
		end
	endtask

	task automatic run_rounds(input int rounds);
		logic [63:0] rd;
		reg_write(`PR_REG_NVERT, 64'(N_VERT));
		reg_write(`PR_REG_NEDGE, 64'(n_edges));
		reg_write(`PR_REG_VBASE, VBASE);
		reg_write(`PR_REG_EBASE, EBASE);
		// bases were swapped by the previous run
		reg_write(`PR_REG_ADDR0, ADDR0);
		reg_write(`PR_REG_ADDR1, ADDR1);
		reg_write(`PR_REG_ROUNDS, 64'(rounds));
		reg_read(`PR_REG_NVERT, rd);
		compare("nvert readback", 64'(N_VERT), rd);
		reg_write(`PR_REG_START, 64'd1);
		wait_done(rounds);
		reg_read(`PR_REG_DONE_ROUNDS, rd);
		compare("completed rounds", 64'(rounds), rd);
	endtask

	task automatic check_scores(input string name, input logic [63:0] base);
		for (int v = 0; v < N_VERT; v++)
			compare($sformatf("%s vertex %0d", name, v), exp_score[v],
				u_mem_model.mem[int'(base >> 3) + v]);
	endtask

	task automatic check_fill(input string name, input logic [63:0] base);
		for (int v = 0; v < N_VERT; v++)
			compare($sformatf("%s vertex %0d", name, v), fill_word(int'(base >> 3) + v),
				u_mem_model.mem[int'(base >> 3) + v]);
	endtask

	initial begin
		rst = 1'b1;
		softreg_req_valid = 1'b0;
		softreg_req_is_write = 1'b0;
		softreg_req_addr = '0;
		softreg_req_data = '0;
		stall = '0;
		stall_en = 1'b0;
		lfsr = 32'h94db8c46;
		build_graph();
		load_memory();
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;

		// status right after reset
		reg_read(`PR_REG_STATE, rd_val);
		compare("state after reset", 64'(IDLE), rd_val);

		// one round writes ADDR1 and leaves ADDR0 alone
		run_rounds(1);
		pr_expect(1);
		check_scores("round 1 in addr1", ADDR1);
		check_fill("addr0 untouched", ADDR0);
		compare("zero in-degree vertex", 64'd0, u_mem_model.mem[int'(ADDR1 >> 3)]);
		compare("zero out-degree vertex", 64'(in_deg[N_VERT-1]) * INIT_SCORE,
			u_mem_model.mem[int'(ADDR1 >> 3) + N_VERT - 1]);

		// four rounds ping-pong between the arrays
		load_memory();
		run_rounds(4);
		pr_expect(3);
		check_scores("round 3 in addr1", ADDR1);
		pr_expect(4);
		check_scores("round 4 in addr0", ADDR0);

		// same run with every channel stalling at random
		load_memory();
		stall_en = 1'b1;
		run_rounds(4);
		stall_en = 1'b0;
		pr_expect(3);
		check_scores("stalled round 3 in addr1", ADDR1);
		pr_expect(4);
		check_scores("stalled round 4 in addr0", ADDR0);

		$display("TEST PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
+incdir+include
source/pr_pkg.sv
source/pr_round_if.sv
source/pr_fifo.sv
source/pr_divider.sv
source/pr_control.sv
source/pr_mem_reader.sv
source/pr_vertex_engine.sv
source/pr_writeback.sv
source/pagerank_top.sv
bench/pr_mem_model.sv
bench/tb_pagerank.sv

// File: run.sh
#!/usr/bin/env bash
# build the testbench with Verilator and run it
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_pagerank -f src.f -o tb_pagerank
status=$?
if [ $status -ne 0 ]; then
	echo "build failed"
	exit $status
fi

./obj_dir/tb_pagerank
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed"
	exit $status
fi
exit 0
